/* dv/ioSubsystemTb.sv */
////////////////////////////////////////
// Testbench for the I/O subsystem
// Timer model, UART frame decoder and
// read mux checks
////////////////////////////////////////
`default_nettype none

module ioSubsystemTb;

    localparam int FIFO_DEPTH   = 4;
    localparam int CLKS_PER_BIT = 4;
    // Full sequence runs well under 1500 cycles
    localparam longint MAX_CYCLES = 4000;
    localparam logic [31:0] LFSR_MASK = 32'hB4BC_D35C;

    logic                clk;
    logic                rstN;
    ioMapPkg::ioWriteReq wrReq;
    ioMapPkg::ioAddr     rdAddr;
    ioMapPkg::ioData     gazeIn;
    ioMapPkg::ioData     rdData;
    logic                timerIrq;
    logic                txd;

    logic [31:0]         lfsr = 32'd84177;
    longint              cycleCount = 0;
    logic [63:0]         mtimeBase;
    longint              baseCycle;
    logic [63:0]         cmpModel;
    bit                  modelOn = 1'b0;
    int                  irqHighCycles = 0;
    ioDevPkg::serialByte expectedBytes[$];

    ioSubsystem #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .wrReq    (wrReq),
        .rdAddr   (rdAddr),
        .gazeIn   (gazeIn),
        .rdData   (rdData),
        .timerIrq (timerIrq),
        .txd      (txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else
            reportFailure($sformatf("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                                    $time, name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            reportFailure($sformatf("Timeout, run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Last written value plus the cycles since that write
    function automatic logic [63:0] modelMtime();
        return mtimeBase + 64'(cycleCount - baseCycle);
    endfunction

    // Called at a falling edge, returns at the next one
    task automatic writeReg(input ioMapPkg::ioAddr addr, input ioMapPkg::ioData data);
        logic [63:0] nextMtime;
        nextMtime = modelMtime() + 64'd1;
        wrReq = '{we: 1'b1, addr: addr, data: data};
        @(negedge clk);
        wrReq.we = 1'b0;
        case (addr)
            ioMapPkg::ADDR_TIMER_LOW:     nextMtime[31:0] = data;
            ioMapPkg::ADDR_TIMER_HI:      nextMtime[63:32] = data;
            ioMapPkg::ADDR_TIMER_CMP_LOW: cmpModel[31:0] = data;
            ioMapPkg::ADDR_TIMER_CMP_HI:  cmpModel[63:32] = data;
            default: ;
        endcase
        mtimeBase = nextMtime;
        baseCycle = cycleCount;
    endtask

    task automatic readCheck(input ioMapPkg::ioAddr addr, input logic [63:0] expected,
                             input string name);
        rdAddr = addr;
        #1;
        checkValue(name, expected, rdData);
        @(negedge clk);
    endtask

    task automatic checkMtime();
        logic [63:0] now;
        now = modelMtime();
        readCheck(ioMapPkg::ADDR_TIMER_LOW, now[31:0], "rdData mtimeLow");
        now = modelMtime();
        readCheck(ioMapPkg::ADDR_TIMER_HI, now[63:32], "rdData mtimeHi");
    endtask

    task automatic sendByte(input ioDevPkg::serialByte b, input bit accept);
        ioMapPkg::ioData upper;
        if (accept) begin
            expectedBytes.push_back(b);
        end
        upper = nextBits(24);
        writeReg(ioMapPkg::ADDR_SERIAL_OUTPUT, {upper[23:0], b});
    endtask

    // Queue empty, UART idle and every expected frame seen
    task automatic waitSerialIdle();
        ioDevPkg::serialStatus st;
        rdAddr = ioMapPkg::ADDR_SERIAL_STATUS;
        forever begin
            #1;
            st = ioDevPkg::serialStatus'(rdData[$bits(ioDevPkg::serialStatus)-1:0]);
            if (st.empty && !st.txBusy && expectedBytes.size() == 0) begin
                break;
            end
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // Interrupt level against the reference timer, every cycle
    always @(negedge clk) begin
        #1;
        if (modelOn) begin
            checkValue("timerIrq", 64'(modelMtime() >= cmpModel), 64'(timerIrq));
            if (timerIrq) begin
                irqHighCycles++;
            end
        end
    end

    // 8N1 decoder, samples near the middle of each bit
    initial begin : uartMonitor
        ioDevPkg::serialByte rxByte;
        ioDevPkg::serialByte expByte;
        wait (modelOn);
        forever begin
            @(negedge txd);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            checkValue("txd start bit", 64'd0, txd);
            for (int i = 0; i < ioDevPkg::SERIAL_WIDTH; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rxByte[i] = txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            checkValue("txd stop bit", 64'd1, txd);
            if (expectedBytes.size() == 0) begin
                reportFailure("A frame appeared on txd with no accepted byte pending");
            end else begin
                expByte = expectedBytes.pop_front();
                checkValue("txd data", expByte, rxByte);
            end
        end
    end

    initial begin : mainSequence
        ioMapPkg::ioData       word;
        logic [63:0]           now;
        ioDevPkg::serialStatus expSt;
        int                    highBefore;

        rstN   = 1'b0;
        wrReq  = '0;
        rdAddr = '0;
        gazeIn = '0;
        repeat (8) @(negedge clk);
        rstN      = 1'b1;
        mtimeBase = '0;
        baseCycle = cycleCount;
        cmpModel  = '1;
        modelOn   = 1'b1;

        // Reset state
        #1;
        checkValue("txd", 64'd1, txd);
        checkValue("timerIrq", 64'd0, timerIrq);
        @(negedge clk);
        readCheck(ioMapPkg::ADDR_TIMER_CMP_LOW, 64'hFFFF_FFFF, "rdData mtimecmpLow");
        readCheck(ioMapPkg::ADDR_TIMER_CMP_HI, 64'hFFFF_FFFF, "rdData mtimecmpHi");
        expSt = '{overflow: 1'b0, full: 1'b0, empty: 1'b1, txBusy: 1'b0};
        readCheck(ioMapPkg::ADDR_SERIAL_STATUS, ioMapPkg::ioData'(expSt), "rdData status");

        // Random timer writes and read back
        for (int i = 0; i < 6; i++) begin
            writeReg(ioMapPkg::ADDR_TIMER_LOW, nextBits(32));
            writeReg(ioMapPkg::ADDR_TIMER_HI, nextBits(32));
            repeat (nextBits(3)) @(negedge clk);
            checkMtime();
            word = nextBits(32);
            writeReg(ioMapPkg::ADDR_TIMER_CMP_LOW, word);
            readCheck(ioMapPkg::ADDR_TIMER_CMP_LOW, word, "rdData mtimecmpLow");
            word = nextBits(32);
            writeReg(ioMapPkg::ADDR_TIMER_CMP_HI, word);
            readCheck(ioMapPkg::ADDR_TIMER_CMP_HI, word, "rdData mtimecmpHi");
        end
        // Carry from the low half into the high half
        writeReg(ioMapPkg::ADDR_TIMER_HI, nextBits(32));
        writeReg(ioMapPkg::ADDR_TIMER_LOW, 32'hFFFF_FFF8);
        repeat (12) @(negedge clk);
        checkMtime();

        // Compare set a few counts ahead of mtime
        writeReg(ioMapPkg::ADDR_TIMER_LOW, 32'h0000_1000);
        now = modelMtime();
        writeReg(ioMapPkg::ADDR_TIMER_CMP_LOW, now[31:0] + 32'd12);
        writeReg(ioMapPkg::ADDR_TIMER_CMP_HI, now[63:32]);
        #1;
        checkValue("timerIrq", 64'd0, timerIrq);
        @(negedge clk);
        highBefore = irqHighCycles;
        repeat (20) @(negedge clk);
        if (irqHighCycles == highBefore) begin
            reportFailure("timerIrq never rose after mtime passed mtimecmp");
        end

        // Spaced serial bytes, all accepted
        for (int i = 0; i < 6; i++) begin
            sendByte(ioDevPkg::serialByte'(nextBits(8)), 1'b1);
            repeat (32 + nextBits(4)) @(negedge clk);
        end
        waitSerialIdle();

        // Burst from idle, only FIFO_DEPTH+1 get through
        for (int i = 0; i < 10; i++) begin
            sendByte(ioDevPkg::serialByte'(nextBits(8)), i <= FIFO_DEPTH);
        end
        expSt = '{overflow: 1'b1, full: 1'b1, empty: 1'b0, txBusy: 1'b1};
        readCheck(ioMapPkg::ADDR_SERIAL_STATUS, ioMapPkg::ioData'(expSt), "rdData status");
        writeReg(ioMapPkg::ADDR_SERIAL_STATUS, nextBits(32));
        expSt.overflow = 1'b0;
        readCheck(ioMapPkg::ADDR_SERIAL_STATUS, ioMapPkg::ioData'(expSt), "rdData status");
        waitSerialIdle();
        // Room for a stray extra frame to show up
        repeat (CLKS_PER_BIT * 12) @(negedge clk);

        // Gaze input and unmapped space
        for (int i = 0; i < 8; i++) begin
            gazeIn = nextBits(32);
            readCheck(ioMapPkg::ADDR_GAZE, gazeIn, "rdData gaze");
            word = nextBits(32);
            if (!(word inside {ioMapPkg::ADDR_TIMER_LOW, ioMapPkg::ADDR_TIMER_HI,
                               ioMapPkg::ADDR_TIMER_CMP_LOW, ioMapPkg::ADDR_TIMER_CMP_HI,
                               ioMapPkg::ADDR_SERIAL_OUTPUT, ioMapPkg::ADDR_SERIAL_STATUS,
                               ioMapPkg::ADDR_GAZE})) begin
                readCheck(word, 64'd0, "rdData unmapped");
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/ioDevPkg.sv */
////////////////////////////////////////
// Device-side types
// Timer register pair and serial console
// byte and status word
////////////////////////////////////////
`default_nettype none

package ioDevPkg;

    // Machine timer
    localparam int TIMER_WIDTH = 64;

    typedef struct packed {
        logic [TIMER_WIDTH-1:0] mtime;
        logic [TIMER_WIDTH-1:0] mtimecmp;
    } timerRegs;

    // Compare value out of reset keeps the interrupt quiet
    localparam logic [TIMER_WIDTH-1:0] TIMER_CMP_RESET = '1;

    // Serial console
    localparam int SERIAL_WIDTH = 8;

    typedef logic [SERIAL_WIDTH-1:0] serialByte;

    // Status word, zero-extended to a bus word on read
    typedef struct packed {
        // Sticky, a byte was dropped on a full queue
        logic overflow;
        logic full;
        logic empty;
        // Transmitter is inside a frame
        logic txBusy;
    } serialStatus;

endpackage

`default_nettype wire

/* hw/ioMapPkg.sv */
////////////////////////////////////////
// I/O address map and bus types
// Word-wide write request and the physical
// addresses of every device register
////////////////////////////////////////
`default_nettype none

package ioMapPkg;

    // Bus widths
    localparam int IO_DATA_WIDTH = 32;
    localparam int IO_ADDR_WIDTH = 32;

    typedef logic [IO_ADDR_WIDTH-1:0] ioAddr;
    typedef logic [IO_DATA_WIDTH-1:0] ioData;

    // Single-cycle write strobe with its address and data
    typedef struct packed {
        logic  we;
        ioAddr addr;
        ioData data;
    } ioWriteReq;

    // Machine timer, two words per 64-bit register
    localparam ioAddr ADDR_TIMER_LOW     = 32'h4000_0000;
    localparam ioAddr ADDR_TIMER_HI      = 32'h4000_0004;
    localparam ioAddr ADDR_TIMER_CMP_LOW = 32'h4000_0008;
    localparam ioAddr ADDR_TIMER_CMP_HI  = 32'h4000_000C;

    // Serial console
    localparam ioAddr ADDR_SERIAL_OUTPUT = 32'h4000_1000;
    localparam ioAddr ADDR_SERIAL_STATUS = 32'h4000_1004;

    // Debug gaze input, read only
    localparam ioAddr ADDR_GAZE          = 32'h4000_2000;

endpackage

`default_nettype wire

/* hw/ioSubsystem.sv */
////////////////////////////////////////
// I/O subsystem top level
// I/O unit, serial transmit queue and UART
////////////////////////////////////////
`default_nettype none

module ioSubsystem #(
    parameter int FIFO_DEPTH   = 4,
    parameter int CLKS_PER_BIT = 4
) (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire ioMapPkg::ioWriteReq wrReq,
    input  wire ioMapPkg::ioAddr     rdAddr,
    input  wire ioMapPkg::ioData     gazeIn,
    output ioMapPkg::ioData          rdData,
    output logic                     timerIrq,
    output logic                     txd
);

    logic                  serialPush;
    logic                  statusClear;
    ioDevPkg::serialByte   serialData;
    ioDevPkg::serialByte   fifoHead;
    logic                  fifoEmpty;
    logic                  fifoFull;
    logic                  fifoOverflow;
    logic                  fifoPop;
    logic                  txBusy;
    ioDevPkg::serialStatus status;

    // Status word seen by the core
    assign status = '{
        overflow: fifoOverflow,
        full:     fifoFull,
        empty:    fifoEmpty,
        txBusy:   txBusy
    };

    ioUnit u_ioUnit (
        .clk         (clk),
        .rstN        (rstN),
        .wrReq       (wrReq),
        .rdAddr      (rdAddr),
        .gazeIn      (gazeIn),
        .status      (status),
        .rdData      (rdData),
        .timerIrq    (timerIrq),
        .serialPush  (serialPush),
        .serialData  (serialData),
        .statusClear (statusClear)
    );

    serialTxFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_txFifo (
        .clk           (clk),
        .rstN          (rstN),
        .push          (serialPush),
        .pushData      (serialData),
        .pop           (fifoPop),
        .clearOverflow (statusClear),
        .head          (fifoHead),
        .empty         (fifoEmpty),
        .full          (fifoFull),
        .overflow      (fifoOverflow)
    );

    uartTx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uartTx (
        .clk    (clk),
        .rstN   (rstN),
        .head   (fifoHead),
        .empty  (fifoEmpty),
        .pop    (fifoPop),
        .txBusy (txBusy),
        .txd    (txd)
    );

endmodule

`default_nettype wire

/* hw/ioUnit.sv */
////////////////////////////////////////
// I/O unit
// Write decode, read data mux and the
// serial push path; holds the machine timer
////////////////////////////////////////
`default_nettype none

module ioUnit (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire ioMapPkg::ioWriteReq   wrReq,
    input  wire ioMapPkg::ioAddr       rdAddr,
    input  wire ioMapPkg::ioData       gazeIn,
    input  wire ioDevPkg::serialStatus status,
    output ioMapPkg::ioData            rdData,
    output logic                       timerIrq,
    output logic                       serialPush,
    output ioDevPkg::serialByte        serialData,
    output logic                       statusClear
);

    localparam int HALF = ioMapPkg::IO_DATA_WIDTH;
    localparam int FULL = ioDevPkg::TIMER_WIDTH;

    logic               wrTimerLow;
    logic               wrTimerHi;
    logic               wrCmpLow;
    logic               wrCmpHi;
    ioDevPkg::timerRegs timerRegs;

    // Write decode, one strobe per mapped register
    always_comb begin
        wrTimerLow  = 1'b0;
        wrTimerHi   = 1'b0;
        wrCmpLow    = 1'b0;
        wrCmpHi     = 1'b0;
        serialPush  = 1'b0;
        statusClear = 1'b0;
        if (wrReq.we) begin
            case (wrReq.addr)
                ioMapPkg::ADDR_TIMER_LOW:     wrTimerLow  = 1'b1;
                ioMapPkg::ADDR_TIMER_HI:      wrTimerHi   = 1'b1;
                ioMapPkg::ADDR_TIMER_CMP_LOW: wrCmpLow    = 1'b1;
                ioMapPkg::ADDR_TIMER_CMP_HI:  wrCmpHi     = 1'b1;
                ioMapPkg::ADDR_SERIAL_OUTPUT: serialPush  = 1'b1;
                ioMapPkg::ADDR_SERIAL_STATUS: statusClear = 1'b1;
                default: begin
                    // Writes to gaze or unmapped space are ignored
                end
            endcase
        end
    end

    // Low byte of the bus carries the console character
    assign serialData = wrReq.data[ioDevPkg::SERIAL_WIDTH-1:0];

    machineTimer u_timer (
        .clk      (clk),
        .rstN     (rstN),
        .wrLow    (wrTimerLow),
        .wrHi     (wrTimerHi),
        .wrCmpLow (wrCmpLow),
        .wrCmpHi  (wrCmpHi),
        .wrData   (wrReq.data),
        .regs     (timerRegs),
        .irq      (timerIrq)
    );

    // Read mux, same cycle
    always_comb begin
        case (rdAddr)
            ioMapPkg::ADDR_TIMER_LOW:     rdData = timerRegs.mtime[HALF-1:0];
            ioMapPkg::ADDR_TIMER_HI:      rdData = timerRegs.mtime[FULL-1:HALF];
            ioMapPkg::ADDR_TIMER_CMP_LOW: rdData = timerRegs.mtimecmp[HALF-1:0];
            ioMapPkg::ADDR_TIMER_CMP_HI:  rdData = timerRegs.mtimecmp[FULL-1:HALF];
            ioMapPkg::ADDR_SERIAL_STATUS: rdData = ioMapPkg::ioData'(status);
            ioMapPkg::ADDR_GAZE:          rdData = gazeIn;
            default:                      rdData = '0;
        endcase
    end

    oneWriteStrobe: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0({wrTimerLow, wrTimerHi, wrCmpLow, wrCmpHi, serialPush, statusClear})
    );

endmodule

`default_nettype wire

/* hw/machineTimer.sv */
////////////////////////////////////////
// Machine timer
// Free-running 64-bit mtime, mtimecmp and
// the level timer interrupt
////////////////////////////////////////
`default_nettype none

module machineTimer (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire                   wrLow,
    input  wire                   wrHi,
    input  wire                   wrCmpLow,
    input  wire                   wrCmpHi,
    input  wire ioMapPkg::ioData  wrData,
    output ioDevPkg::timerRegs    regs,
    output logic                  irq
);

    localparam int HALF = ioMapPkg::IO_DATA_WIDTH;
    localparam int FULL = ioDevPkg::TIMER_WIDTH;

    ioDevPkg::timerRegs regsNext;

    always_comb begin
        regsNext = regs;
        // Count first, a half-word write then replaces its half
        regsNext.mtime = regs.mtime + 1'b1;
        if (wrLow) begin
            regsNext.mtime[HALF-1:0] = wrData;
        end
        if (wrHi) begin
            regsNext.mtime[FULL-1:HALF] = wrData;
        end
        if (wrCmpLow) begin
            regsNext.mtimecmp[HALF-1:0] = wrData;
        end
        if (wrCmpHi) begin
            regsNext.mtimecmp[FULL-1:HALF] = wrData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs.mtime    <= '0;
            regs.mtimecmp <= ioDevPkg::TIMER_CMP_RESET;
        end else begin
            regs <= regsNext;
        end
    end

    // Unsigned compare on the registered values
    assign irq = (regs.mtime >= regs.mtimecmp);

    // Same compare built from the two halves
    irqMatchesCompare: assert property (
        @(posedge clk) disable iff (!rstN)
        irq == ((regs.mtime[FULL-1:HALF] > regs.mtimecmp[FULL-1:HALF]) ||
                ((regs.mtime[FULL-1:HALF] == regs.mtimecmp[FULL-1:HALF]) &&
                 (regs.mtime[HALF-1:0] >= regs.mtimecmp[HALF-1:0])))
    );

endmodule

`default_nettype wire

/* hw/serialTxFifo.sv */
////////////////////////////////////////
// Serial transmit queue
// Circular byte buffer with drop on full
// and a sticky overflow flag
////////////////////////////////////////
`default_nettype none

module serialTxFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     push,
    input  wire ioDevPkg::serialByte pushData,
    input  wire                     pop,
    input  wire                     clearOverflow,
    output ioDevPkg::serialByte     head,
    output logic                    empty,
    output logic                    full,
    output logic                    overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(FIFO_DEPTH);

    ioDevPkg::serialByte mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             pushOk;
    logic             popOk;

    assign empty = (count == '0);
    assign full  = (count == FULL_COUNT);

    // A pop in the same cycle frees the slot for the push
    assign pushOk = push && (!full || pop);
    assign popOk  = pop && !empty;

    assign head = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (pushOk) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Drop wins over a clear in the same cycle
            if (push && !pushOk) begin
                overflow <= 1'b1;
            end else if (clearOverflow) begin
                overflow <= 1'b0;
            end
        end
    end

    popNotEmpty: assert property (
        @(posedge clk) disable iff (!rstN) pop |-> !empty
    );

    countInRange: assert property (
        @(posedge clk) disable iff (!rstN) count <= FULL_COUNT
    );

endmodule

`default_nettype wire

/* hw/uartTx.sv */
////////////////////////////////////////
// UART transmitter
// 8N1 serializer that pulls bytes from the
// transmit queue whenever it is idle
////////////////////////////////////////
`default_nettype none

module uartTx #(
    parameter int CLKS_PER_BIT = 4
) (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire ioDevPkg::serialByte head,
    input  wire                      empty,
    output logic                     pop,
    output logic                     txBusy,
    output logic                     txd
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(ioDevPkg::SERIAL_WIDTH);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(ioDevPkg::SERIAL_WIDTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } txState;

    txState              state;
    logic [CNT_W-1:0]    clkCnt;
    logic [IDX_W-1:0]    bitIdx;
    ioDevPkg::serialByte shiftReg;
    logic                bitDone;
    logic                shiftNow;

    assign bitDone = (clkCnt == LAST_CLK);
    assign pop     = (state == IDLE) && !empty;
    assign txBusy  = (state != IDLE);

    // Next data bit goes out at the end of start and of every data bit but the last
    assign shiftNow = bitDone &&
                      ((state == START) || ((state == DATA) && (bitIdx != LAST_BIT)));

    always_ff @(posedge clk) begin
        if (pop) begin
            shiftReg <= head;
        end else if (shiftNow) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= IDLE;
            clkCnt <= '0;
            bitIdx <= '0;
            txd    <= 1'b1;
        end else begin
            clkCnt <= bitDone ? '0 : clkCnt + 1'b1;
            case (state)
                IDLE: begin
                    clkCnt <= '0;
                    if (pop) begin
                        state <= START;
                        txd   <= 1'b0;
                    end
                end
                START: begin
                    if (bitDone) begin
                        state  <= DATA;
                        bitIdx <= '0;
                        txd    <= shiftReg[0];
                    end
                end
                DATA: begin
                    if (bitDone) begin
                        if (bitIdx == LAST_BIT) begin
                            state <= STOP;
                            txd   <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txd    <= shiftReg[0];
                        end
                    end
                end
                default: begin
                    // Stop bit, back to idle to fetch the next byte
                    if (bitDone) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    idleLineHigh: assert property (
        @(posedge clk) disable iff (!rstN) !txBusy |-> txd
    );

endmodule

`default_nettype wire

/* ioSubsystem.f */
hw/ioMapPkg.sv
hw/ioDevPkg.sv
hw/machineTimer.sv
hw/serialTxFifo.sv
hw/uartTx.sv
hw/ioUnit.sv
hw/ioSubsystem.sv
dv/ioSubsystemTb.sv
